//--- verilog.f
src/agusec_pkg.sv
src/get_carry.sv
src/agusec_shift8.sv
src/agusec_check_upper3.sv
src/agusec_range.sv
src/agusec_unit.sv
verif/agusec_unit_tb.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f verilog.f --top-module agusec_unit_tb \
  -Mdir obj_dir -o agusec_unit_tb
./obj_dir/agusec_unit_tb > sim.log 2>&1 || true
cat sim.log
if grep -qx "TEST PASSED" sim.log; then
  exit 0
fi
exit 1

//--- verif/agusec_unit_tb.sv
`timescale 1ns/10ps
`default_nettype none

module agusec_unit_tb;

  logic        clk;
  logic        rst_n;
  logic        in_valid;
  logic [63:0] ptr;
  logic [39:0] opa;
  logic [39:0] opb;
  logic        out_valid;
  logic [39:0] ea;
  logic [2:0]  pos_ack;
  logic [2:0]  neg_ack;
  logic [1:0]  pos_flip;
  logic [1:0]  neg_flip;
  logic        in_bounds;

  integer seed;

  // expected results of the items in flight in issue order
  logic [39:0] ea_q [$];
  logic        ib_q [$];
  logic [63:0] ptr_q [$];

  // the front item is loaded on the falling edge and checked on the next rising edge
  logic        cmp_en = 1'b0;
  logic        rst_seen = 1'b0;
  logic [39:0] cur_ea = '0;
  logic        cur_ib = 1'b0;
  logic [63:0] cur_ptr = '0;

  agusec_unit u_agusec_unit (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .ptr       (ptr),
    .opa       (opa),
    .opb       (opb),
    .out_valid (out_valid),
    .ea        (ea),
    .pos_ack   (pos_ack),
    .neg_ack   (neg_ack),
    .pos_flip  (pos_flip),
    .neg_flip  (neg_flip),
    .in_bounds (in_bounds)
  );

  initial
  begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // the pointer word holds tag at 63, exp at 62:58, hi at 57:51, low at 50:44, addr at 43:4
  // and on_low at 3
  function automatic logic model_in_bounds(input logic [63:0] p);
    logic [39:0] shifted;
    logic [7:0]  sel;
    logic [7:0]  low_lim;
    logic [7:0]  high_lim;
    logic        wrap;
    logic        lo_ok;
    logic        hi_ok;
    shifted  = p[43:4] >> p[62:58];
    sel      = shifted[7:0];
    low_lim  = {p[50:44], 1'b0};
    high_lim = {p[57:51], 1'b1};
    wrap     = p[57:51] < p[50:44];
    lo_ok    = (sel >= low_lim) || (wrap && !p[3]);
    hi_ok    = (sel <= high_lim) || (wrap && p[3]);
    return p[63] && lo_ok && hi_ok;
  endfunction

  task automatic report_mismatch(input string what);
    $display("Mismatch at %0t ns: %s", $time, what);
    $display("TEST FAILED");
    $fatal(1, "stopped at the first wrong value");
  endtask

  task automatic stop_run(input string what);
    $display("Error at %0t ns: %s", $time, what);
    $display("TEST FAILED");
    $fatal(1, "stopped on an error");
  endtask

  task automatic send_item(input logic [63:0] p, input logic [39:0] a, input logic [39:0] b);
    logic [39:0] sum;
    sum = a + b; // wraps modulo 2**40
    @(posedge clk);
    in_valid <= 1'b1;
    ptr      <= p;
    opa      <= a;
    opb      <= b;
    ea_q.push_back(sum);
    ib_q.push_back(model_in_bounds(p));
    ptr_q.push_back(p);
  endtask

  task automatic send_idle();
    @(posedge clk);
    in_valid <= 1'b0;
  endtask

  task automatic send_random(input int mode);
    logic [63:0] p;
    logic [63:0] a;
    logic [63:0] b;
    p = {$random(seed), $random(seed)};
    a = {$random(seed), $random(seed)};
    b = {$random(seed), $random(seed)};
    case (mode)
      1: p[62:58] = agusec_pkg::exp_max;
      2: p[63] = 1'b0;
      3:
      begin
        p[63]    = 1'b1;
        p[57:51] = 7'h7f; // the widest range holds every window
        p[50:44] = 7'h00;
      end
      4:
      begin
        p[63]    = 1'b1;
        p[62:61] = 2'b00; // small exponents select live address bits
      end
      default: ;
    endcase
    send_item(p, a[39:0], b[39:0]);
  endtask

  task automatic drain_pipe();
    int cycles;
    cycles = 0;
    while (ea_q.size() != 0 && cycles < 20)
    begin
      @(posedge clk);
      cycles++;
    end
    if (ea_q.size() != 0)
      stop_run("timed out waiting for the pipeline to drain");
  endtask

  always @(negedge clk)
  begin
    rst_seen = 1'b1;
    if (out_valid === 1'b1)
    begin
      if (ea_q.size() == 0)
        stop_run("out_valid rose with no item in flight");
      else
      begin
        cur_ea  = ea_q.pop_front();
        cur_ib  = ib_q.pop_front();
        cur_ptr = ptr_q.pop_front();
        cmp_en  = 1'b1;
      end
    end
    else
      cmp_en = 1'b0;
  end

  assert property (@(posedge clk)
    (rst_seen && (!rst_n || !$past(rst_n) || !$past(rst_n, 2))) |-> !out_valid)
    else report_mismatch("out_valid high during or just after reset");

  assert property (@(posedge clk)
    ($past(rst_n) && $past(rst_n, 2)) |-> (out_valid == $past(in_valid, 2)))
    else report_mismatch("out_valid does not follow in_valid by two cycles");

  assert property (@(posedge clk) cmp_en |-> (ea == cur_ea))
    else report_mismatch("ea is not opa plus opb of the oldest item");

  assert property (@(posedge clk) cmp_en |-> (in_bounds == cur_ib))
    else report_mismatch("in_bounds differs from the range rule");

  assert property (@(posedge clk) (cmp_en && !cur_ptr[63]) |-> !in_bounds)
    else report_mismatch("untagged pointer reported in bounds");

  assert property (@(posedge clk) (cmp_en && cur_ptr[62:58] == agusec_pkg::exp_max)
    |-> (pos_ack[1:0] == 2'b11 && pos_flip == 2'b00 && neg_flip == 2'b00))
    else report_mismatch("acks or flips wrong at the maximum exponent");

  assert property (@(posedge clk) (cmp_en && cur_ptr[57:51] >= cur_ptr[50:44])
    |-> (pos_flip == 2'b00 && neg_flip == 2'b00 && !neg_ack[0]))
    else report_mismatch("flip or neg_ack[0] set without a wrapped range");

  initial
  begin
    int i;
    seed     = 32'ha13dfe52;
    rst_n    = 1'b0;
    in_valid = 1'b1; // the DUT must drop anything offered during reset
    ptr      = '0;
    opa      = '0;
    opb      = '0;
    repeat (10) @(posedge clk);
    rst_n    <= 1'b1;
    in_valid <= 1'b0;
    repeat (3) send_idle();

    send_random(3); // a lone item first
    repeat (4) send_idle();
    drain_pipe();

    for (i = 0; i < 300; i++)
      send_random(i % 5);
    for (i = 0; i < 200; i++)
    begin
      if (($random(seed) & 1) != 0)
        send_random(i % 5);
      else
        send_idle();
    end
    send_idle();
    drain_pipe();

    if (ea_q.size() == 0)
    begin
      $display("TEST PASSED");
      $finish;
    end
    else
      stop_run("items were left in flight at the end");
  end

endmodule

`default_nettype wire

//--- src/agusec_unit.sv
`timescale 1ns/10ps
`default_nettype none

module agusec_unit #(
  parameter int upper_cmp_w = agusec_pkg::bound_w,
  parameter int range_cmp_w = agusec_pkg::bound_w + 1
) (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          in_valid,
  input  logic [63:0]                   ptr,
  input  logic [agusec_pkg::addr_w-1:0] opa,
  input  logic [agusec_pkg::addr_w-1:0] opb,
  output logic                          out_valid,
  output logic [agusec_pkg::addr_w-1:0] ea,
  output logic [2:0]                    pos_ack,
  output logic [2:0]                    neg_ack,
  output logic [1:0]                    pos_flip,
  output logic [1:0]                    neg_flip,
  output logic                          in_bounds
);

  logic                          s1_valid;
  agusec_pkg::cap_ptr_u          s1_ptr;
  logic [agusec_pkg::addr_w-1:0] s1_opa;
  logic [agusec_pkg::addr_w-1:0] s1_opb;

  logic [2:0] pos_ack_c;
  logic [2:0] neg_ack_c;
  logic [1:0] pos_flip_c;
  logic [1:0] neg_flip_c;
  logic       nhi_less;
  logic       in_bounds_c;

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      s1_valid  <= 1'b0;
      out_valid <= 1'b0;
    end
    else
    begin
      s1_valid  <= in_valid;
      out_valid <= s1_valid; // no stalls, valid simply walks down the pipe
    end
  end

  always_ff @(posedge clk)
  begin
    if (in_valid)
    begin
      s1_ptr.raw <= ptr;
      s1_opa     <= opa;
      s1_opb     <= opb;
    end
    if (s1_valid)
    begin
      ea        <= s1_opa + s1_opb; // wraps modulo 2**40
      pos_ack   <= pos_ack_c;
      neg_ack   <= neg_ack_c;
      pos_flip  <= pos_flip_c;
      neg_flip  <= neg_flip_c;
      in_bounds <= in_bounds_c;
    end
  end

  agusec_check_upper3 #(.cmp_w(upper_cmp_w)) u_check_upper3 (
    .ptr      (s1_ptr.raw),
    .a        (s1_opa),
    .b        (s1_opb),
    .pos_ack  (pos_ack_c),
    .neg_ack  (neg_ack_c),
    .pos_flip (pos_flip_c),
    .neg_flip (neg_flip_c),
    .nhi_less (nhi_less)
  );

  agusec_range #(.cmp_w(range_cmp_w)) u_range (
    .ptr       (s1_ptr.raw),
    .cin_secq  (s1_ptr.cap.tag), // an untagged pointer is never in bounds
    .diff      (~nhi_less),
    .cout_secq (in_bounds_c)
  );

endmodule

`default_nettype wire

//--- src/agusec_range.sv
`timescale 1ns/10ps
`default_nettype none

module agusec_range #(
  parameter int cmp_w = 8
) (
  input  logic [63:0] ptr,
  input  logic        cin_secq,
  input  logic        diff,
  output logic        cout_secq
);

  agusec_pkg::cap_ptr_u p;

  logic [cmp_w-1:0] low_lim;
  logic [cmp_w-1:0] high_lim;
  logic [cmp_w-1:0] bits;
  logic lo_pass;
  logic hi_pass;
  logic cout_low;
  logic cout_high;

  assign p        = ptr;
  assign low_lim  = {p.cap.low, 1'b0};
  assign high_lim = {p.cap.hi, 1'b1};

  // in a wrapped range the on_low flag says which side cannot be crossed
  assign lo_pass = diff & ~p.cap.on_low;
  assign hi_pass = diff & p.cap.on_low;

  agusec_shift8 u_shift8 (
    .exp  (p.cap.exp),
    .addr (p.cap.addr),
    .bits (bits)
  );

  get_carry #(.width(cmp_w)) u_cmp_low (.a(~low_lim), .b(bits), .cin(1'b1), .cout(cout_low));
  get_carry #(.width(cmp_w)) u_cmp_high (.a(high_lim), .b(~bits), .cin(1'b1), .cout(cout_high));

  assign cout_secq = cin_secq & (cout_low | lo_pass) & (cout_high | hi_pass);

endmodule

`default_nettype wire

//--- src/agusec_check_upper3.sv
`timescale 1ns/10ps
`default_nettype none

module agusec_check_upper3 #(
  parameter int cmp_w = 7
) (
  input  logic [63:0]                   ptr,
  input  logic [agusec_pkg::addr_w-1:0] a,
  input  logic [agusec_pkg::addr_w-1:0] b,
  output logic [2:0]                    pos_ack,
  output logic [2:0]                    neg_ack,
  output logic [1:0]                    pos_flip,
  output logic [1:0]                    neg_flip,
  output logic                          nhi_less
);

  agusec_pkg::cap_ptr_u p;

  logic [4:0] exp;
  logic [agusec_pkg::addr_w:0] o_w; // OR of the operands, zero guard on top
  logic [agusec_pkg::addr_w:0] x_w; // XOR, guard bit set
  logic [agusec_pkg::addr_w:0] a_w; // AND, guard bit set
  logic diff;
  logic on_hi;
  logic max;
  logic [7:0] msk;
  logic [7:0] msk0;
  logic [3:0] above;
  logic [3:0] at;

  logic [3:0] pos0;
  logic [3:0] pos1;
  logic [3:0] pos2;
  logic [3:0] pos3;
  logic [3:0] pos_p;
  logic [3:0] neg0;
  logic [3:0] neg1;
  logic [3:0] neg2;
  logic [3:0] neg3;
  logic [3:0] xpos0;
  logic [3:0] xpos1;
  logic [3:0] xpos2;
  logic [3:0] xpos3;
  logic [3:0] xpos_p;
  logic [3:0] xneg0;
  logic [3:0] xneg1;
  logic [3:0] xneg2;
  logic [3:0] xneg3;

  logic do_pos;
  logic do_pos1;
  logic do_pos2;
  logic do_pos3;
  logic do_neg;
  logic do_neg1;
  logic do_neg2;
  logic do_neg3;
  logic do_neg_p;

  assign p     = ptr;
  assign exp   = p.cap.exp;
  assign o_w   = {1'b0, a | b};
  assign x_w   = {1'b1, a ^ b};
  assign a_w   = {1'b1, a & b};
  assign diff  = ~nhi_less; // bounds wrap when hi is below low
  assign on_hi = ~p.cap.on_low;
  assign max   = exp == agusec_pkg::exp_max;

  // hi minus low, carry out set when hi >= low
  get_carry #(.width(cmp_w)) u_hi_cmp (
    .a    (p.cap.hi),
    .b    (~p.cap.low),
    .cin  (1'b1),
    .cout (nhi_less)
  );

  // bit mask inside the eight-bit window picked by exp[2:0]
  assign msk[0] = 1'b0;
  assign msk[1] = exp[2:1] == 2'b00;
  assign msk[2] = exp[2:0] <= 3'd2;
  assign msk[3] = ~exp[2] && exp[1:0] != 2'b11;
  assign msk[4] = ~exp[2];
  assign msk[5] = exp[2:0] <= 3'd4;
  assign msk[6] = exp[2:0] <= 3'd5;
  assign msk[7] = ~&exp[2:0];

  assign msk0 = {1'b1, msk[7:1]} & msk;

  always_comb
  begin
    for (int w = 0; w < 4; w++)
    begin
      above[w] = exp[4:3] < w; // window lies wholly above the exponent
      at[w]    = exp[4:3] == w;

      pos0[w]  = ~above[w] | ~|o_w[w*8+8 +: 8];
      pos1[w]  = above[w] & |p.raw[w*8+12 +: 8];
      pos2[w]  = ~above[w] | ~|o_w[w*8+9 +: 8];
      pos3[w]  = ~at[w] | ~|o_w[w*8+9 +: 8];
      pos_p[w] = ~above[w] & ~&p.raw[w*8+12 +: 8];
      neg0[w]  = ~above[w] | &x_w[w*8+8 +: 8];
      neg1[w]  = ~above[w] | &a_w[w*8+8 +: 8];
      neg2[w]  = ~above[w] | &x_w[w*8+9 +: 8];
      neg3[w]  = ~at[w] | &x_w[w*8+9 +: 8];

      // partial window at the exponent, only the masked bits count
      xpos0[w]  = ~at[w] | ~|(o_w[w*8+8 +: 8] & msk);
      xpos1[w]  = at[w] & |(p.raw[w*8+12 +: 8] & msk);
      xpos2[w]  = ~at[w] | ~(|(o_w[w*8+9 +: 8] & msk) & |(x_w[w*8+9 +: 8] & msk0));
      xpos3[w]  = ~at[w] | ~|(o_w[w*8+1 +: 8] & msk);
      xpos_p[w] = ~at[w] | ~&(p.raw[w*8+12 +: 8] | ~msk);
      xneg0[w]  = ~at[w] | &(x_w[w*8+8 +: 8] | ~msk);
      xneg1[w]  = ~at[w] | &(a_w[w*8+8 +: 8] | ~msk);
      xneg2[w]  = ~at[w] | (&(x_w[w*8+9 +: 8] | ~msk) & ~|(a_w[w*8+9 +: 8] & msk0));
      xneg3[w]  = ~at[w] | &(x_w[w*8+1 +: 8] | ~msk);
    end
  end

  assign do_pos   = &{pos0, xpos0};
  assign do_pos1  = |{pos1, xpos1};
  assign do_pos2  = &{pos2, xpos2} & (exp != agusec_pkg::exp_top);
  assign do_pos3  = do_pos & &{pos3, xpos3};
  assign do_neg   = &{neg0, xneg0};
  assign do_neg1  = &{neg1, xneg1} & (exp != agusec_pkg::exp_top);
  assign do_neg2  = &{neg2, xneg2} & (exp != agusec_pkg::exp_top);
  assign do_neg3  = do_neg & &{neg3, xneg3};
  assign do_neg_p = ~&{pos_p, xpos_p};

  assign pos_ack[0] = do_pos | (do_pos2 & ~on_hi & diff & ~do_neg_p) | max; // carry in of 0
  assign pos_ack[1] = (do_pos & ~on_hi & diff & ~do_neg_p) | max;           // carry in of 1
  assign pos_ack[2] = do_pos3;
  assign neg_ack[0] = do_neg & on_hi & diff & do_pos1;
  assign neg_ack[1] = do_neg | ((do_neg2 | do_neg1) & on_hi & diff & do_pos1);
  assign neg_ack[2] = do_neg3;

  // flips only matter when the range wraps
  assign pos_flip[0] = do_pos2 & ~do_pos & ~on_hi & diff & ~max;
  assign pos_flip[1] = do_pos & ~on_hi & diff & ~max;
  assign neg_flip[0] = do_neg & on_hi & diff & ~max;
  assign neg_flip[1] = (do_neg2 | do_neg1) & ~do_neg & on_hi & diff & ~max;

endmodule

`default_nettype wire

//--- src/agusec_shift8.sv
`timescale 1ns/10ps
`default_nettype none

module agusec_shift8 (
  input  logic [4:0]                    exp,
  input  logic [agusec_pkg::addr_w-1:0] addr,
  output logic [7:0]                    bits
);

  logic [agusec_pkg::addr_w-1:0] sh16;
  logic [agusec_pkg::addr_w-1:0] sh8;
  logic [agusec_pkg::addr_w-1:0] sh4;
  logic [agusec_pkg::addr_w-1:0] sh2;
  logic [agusec_pkg::addr_w-1:0] sh1;

  // one stage per exponent bit, largest distance first
  always_comb
  begin
    sh16 = addr;
    if (exp[4])
      sh16 = addr >> 16;
    sh8 = sh16;
    if (exp[3])
      sh8 = sh16 >> 8;
    sh4 = sh8;
    if (exp[2])
      sh4 = sh8 >> 4;
    sh2 = sh4;
    if (exp[1])
      sh2 = sh4 >> 2;
    sh1 = sh2;
    if (exp[0])
      sh1 = sh2 >> 1;
  end

  assign bits = sh1[7:0]; // bits shifted in from above bit 39 are zero

endmodule

`default_nettype wire

//--- src/get_carry.sv
`timescale 1ns/10ps
`default_nettype none

module get_carry #(
  parameter int width = 8
) (
  input  logic [width-1:0] a,
  input  logic [width-1:0] b,
  input  logic             cin,
  output logic             cout
);

  localparam int levels = $clog2(width + 1);

  // position 0 holds cin as a pure generate, operand bit i sits at position i+1
  logic [width:0] g_lv [0:levels];
  logic [width:0] p_lv [0:levels];

  always_comb
  begin
    g_lv[0] = {a & b, cin};
    p_lv[0] = {a ^ b, 1'b0};
    for (int l = 0; l < levels; l++)
    begin
      for (int i = 0; i <= width; i++)
      begin
        if (i >= (1 << l))
        begin
          g_lv[l+1][i] = g_lv[l][i] | (p_lv[l][i] & g_lv[l][i-(1<<l)]);
          p_lv[l+1][i] = p_lv[l][i] & p_lv[l][i-(1<<l)];
        end
        else
        begin
          g_lv[l+1][i] = g_lv[l][i]; // group already reaches cin
          p_lv[l+1][i] = p_lv[l][i];
        end
      end
    end
  end

  assign cout = g_lv[levels][width];

endmodule

`default_nettype wire

//--- src/agusec_pkg.sv
`default_nettype none

package agusec_pkg;

  // operand and address width of the AGU datapath
  localparam int addr_w = 40;

  // width of the hi and low bound fields
  localparam int bound_w = 7;

  localparam logic [4:0] exp_max = 5'd31; // all-ones exponent, acks are forced here
  localparam logic [4:0] exp_top = 5'd30; // second-level carries are suppressed at this exponent

  // named view of a compressed capability word, msb first
  typedef struct packed {
    logic               tag;    // capability is valid
    logic [4:0]         exp;
    logic [bound_w-1:0] hi;     // upper bound, in units of 2**exp
    logic [bound_w-1:0] low;    // lower bound
    logic [addr_w-1:0]  addr;   // word bits 43 to 4
    logic               on_low; // address sits in the lower region of a wrapped range
    logic [2:0]         rsvd;
  } cap_fields_t;

  // the check logic slices raw by address bit while the range
  // logic reads the named fields of the same word
  typedef union packed {
    logic [63:0] raw;
    cap_fields_t cap;
  } cap_ptr_u;

endpackage

`default_nettype wire
